//--- src.f
common/standby_pkg.sv
logic/sync_fifo.sv
flow/flow_standby_i2c.sv
flow/i2c_standby_top.sv
tests/tb_i2c_standby.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the standby I2C flow testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_i2c_standby -f src.f -o sim_i2c_standby
./obj_dir/sim_i2c_standby | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

//--- tests/tb_i2c_standby.sv
// Testbench for the standby I2C target flow that drives bus events and host queues and checks by assertion
`timescale 1ns/1ps

module tb_i2c_standby
  import standby_pkg::*;
();

  localparam int QueueDepth = 4;
  localparam int Timeout    = 200;
  localparam int ReadLen    = 5;
  localparam logic [7:0] WriteAddr = 8'ha4;
  localparam logic [7:0] ReadAddr  = 8'ha5;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 acq_valid_i;
  acq_entry_t           acq_i;
  logic                 tx_byte_valid_o, tx_byte_ready_i;
  logic [7:0]           tx_byte_o;
  logic                 cmd_valid_i, cmd_ready_o;
  cmd_desc_t            cmd_i;
  logic                 txq_valid_i, txq_ready_o;
  logic [WordWidth-1:0] txq_data_i, rx_data_o;
  logic                 rx_valid_o, rx_ready_i;
  logic                 resp_valid_o, resp_ready_i;
  resp_desc_t           resp_o;
  logic                 err_o;

  // Expected traffic indexed by the number of handshakes seen so far
  logic [31:0] exp_rx [$];
  resp_desc_t  exp_resp [$];
  logic [7:0]  exp_tx [$];
  int          rx_seen = 0;
  int          resp_seen = 0;
  int          tx_seen = 0;
  bit          err_allowed = 1'b0;
  int          seed = 32'hc5c0;
  logic [31:0] tx_word;

  i2c_standby_top #(.QueueDepth(QueueDepth)) dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (rx_valid_o && rx_ready_i) rx_seen <= rx_seen + 1;
    if (resp_valid_o && resp_ready_i) resp_seen <= resp_seen + 1;
    if (tx_byte_valid_o && tx_byte_ready_i) tx_seen <= tx_seen + 1;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    report_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  rx_word_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_o && rx_ready_i |-> rx_data_o == exp_rx[rx_seen])
    else report_mismatch("rx_data_o", $sampled(rx_data_o), exp_rx[$sampled(rx_seen)]);
  resp_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && resp_ready_i |-> resp_o == exp_resp[resp_seen])
    else report_mismatch("resp_o", 32'($sampled(resp_o)), 32'(exp_resp[$sampled(resp_seen)]));
  tx_byte_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && tx_byte_ready_i |-> tx_byte_o == exp_tx[tx_seen])
    else report_mismatch("tx_byte_o", 32'($sampled(tx_byte_o)), 32'(exp_tx[$sampled(tx_seen)]));
  err_check: assert property (@(posedge clk_i) disable iff (!rst_ni) err_o |-> err_allowed)
    else report_failure("err_o rose although no fault was injected");

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic check_idle();
    expect_bit("tx_byte_valid_o", tx_byte_valid_o, 1'b0);
    expect_bit("rx_valid_o", rx_valid_o, 1'b0);
    expect_bit("resp_valid_o", resp_valid_o, 1'b0);
    expect_bit("err_o", err_o, 1'b0);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // One strobe followed by idle cycles so a push state can finish before the next event
  task automatic send_event(input acq_id_e id, input logic [7:0] data);
    @(posedge clk_i);
    acq_valid_i <= 1'b1;
    acq_i.id    <= id;
    acq_i.data  <= data;
    @(posedge clk_i);
    acq_valid_i <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  // Random bytes packed little endian into expected words with zero padding
  task automatic send_write_bytes(input int count, input bit track);
    logic [7:0]  data [$];
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < count; i++) begin
      data.push_back(8'($random(seed)));
      word[8*(i%4) +: 8] = data[i];
      if (i % 4 == 3 || i == count - 1) begin
        if (track) exp_rx.push_back(word);
        word = '0;
      end
    end
    foreach (data[i]) send_event(AcqData, data[i]);
  endtask

  task automatic expect_response(input int len);
    resp_desc_t resp;
    resp.data_length = 16'(len);
    resp.err_status  = RespOk;
    exp_resp.push_back(resp);
  endtask

  task automatic push_cmd(input logic [15:0] len);
    int waited;
    waited = 0;
    @(posedge clk_i);
    cmd_valid_i       <= 1'b1;
    cmd_i.data_length <= len;
    @(negedge clk_i);
    while (!cmd_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_failure("cmd_ready_o never rose for the command");
    end
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic push_txq(input logic [31:0] word);
    int waited;
    waited = 0;
    @(posedge clk_i);
    txq_valid_i <= 1'b1;
    txq_data_i  <= word;
    @(negedge clk_i);
    while (!txq_ready_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_failure("txq_ready_o never rose for the transmit word");
    end
    @(posedge clk_i);
    txq_valid_i <= 1'b0;
  endtask

  task automatic take_rx();
    int waited;
    waited = 0;
    @(posedge clk_i);
    rx_ready_i <= 1'b1;
    while (rx_seen != exp_rx.size()) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_failure("rx_valid_o never delivered all receive words");
    end
    @(posedge clk_i);
    rx_ready_i <= 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (resp_seen != exp_resp.size()) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_failure("resp_valid_o never delivered all responses");
    end
  endtask

  // Ready toggles at random while the read bytes come out
  task automatic collect_tx_bytes();
    int waited;
    waited = 0;
    while (tx_seen != exp_tx.size()) begin
      @(posedge clk_i);
      tx_byte_ready_i <= 1'($random(seed));
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_failure("tx_byte_valid_o never delivered all read bytes");
    end
    @(posedge clk_i);
    tx_byte_ready_i <= 1'b0;
  endtask

  task automatic wait_err();
    int waited;
    waited = 0;
    while (!err_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > Timeout) report_failure("err_o never rose after the injected fault");
    end
  endtask

  initial begin
    rst_ni          = 1'b0;
    acq_valid_i     = 1'b0;
    acq_i           = '0;
    tx_byte_ready_i = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_i           = '0;
    txq_valid_i     = 1'b0;
    txq_data_i      = '0;
    rx_ready_i      = 1'b0;
    resp_ready_i    = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_idle();
    expect_bit("cmd_ready_o", cmd_ready_o, 1'b0);
    expect_bit("txq_ready_o", txq_ready_o, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle();
    @(posedge clk_i);
    resp_ready_i <= 1'b1;

    // Write closed by stop gives one full and one padded word
    send_event(AcqStart, WriteAddr);
    send_write_bytes(6, 1'b1);
    expect_response(6);
    send_event(AcqStop, 8'h00);
    take_rx();
    wait_responses();

    // Restart splits two writes that each get their own response
    send_event(AcqStart, WriteAddr);
    send_write_bytes(3, 1'b1);
    expect_response(3);
    send_event(AcqRestart, WriteAddr);
    send_write_bytes(2, 1'b1);
    expect_response(2);
    send_event(AcqStop, 8'h00);
    take_rx();
    wait_responses();

    // Host stops draining responses so any response from the read stays visible
    @(posedge clk_i);
    resp_ready_i <= 1'b0;

    // Read across two transmit words with the least significant byte first
    push_cmd(16'(ReadLen));
    for (int w = 0; w < 2; w++) begin
      tx_word = $random(seed);
      push_txq(tx_word);
      for (int b = 0; b < 4; b++) begin
        if (4 * w + b < ReadLen) exp_tx.push_back(tx_word[8*b +: 8]);
      end
    end
    send_event(AcqStart, ReadAddr);
    collect_tx_bytes();
    send_event(AcqStop, 8'h00);
    repeat (4) @(negedge clk_i);
    expect_bit("resp_valid_o", resp_valid_o, 1'b0);
    expect_bit("tx_byte_valid_o", tx_byte_valid_o, 1'b0);

    // Zero length read is a fault that holds until reset
    err_allowed = 1'b1;
    push_cmd(16'd0);
    send_event(AcqStart, ReadAddr);
    wait_err();
    repeat (5) @(negedge clk_i);
    expect_bit("err_o", err_o, 1'b1);
    apply_reset();
    err_allowed = 1'b0;
    @(negedge clk_i);
    expect_bit("err_o", err_o, 1'b0);

    // Receive queue fills up and one more data byte arrives while the word waits
    err_allowed = 1'b1;
    send_event(AcqStart, WriteAddr);
    send_write_bytes((QueueDepth + 1) * 4 + 1, 1'b0);
    wait_err();
    apply_reset();
    err_allowed = 1'b0;

    if (rx_seen != exp_rx.size() || resp_seen != exp_resp.size() || tx_seen != exp_tx.size())
      report_failure("Expected traffic was left over at the end of the run");
    else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- flow/i2c_standby_top.sv
// Top level of the standby I2C target flow; connects the flow FSM to its four host queues
`timescale 1ns/1ps

module i2c_standby_top
  import standby_pkg::*;
#(
  parameter int QueueDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Bus engine side
  input  logic                 acq_valid_i,
  input  acq_entry_t           acq_i,
  output logic                 tx_byte_valid_o,
  output logic [7:0]           tx_byte_o,
  input  logic                 tx_byte_ready_i,
  // Host side
  input  logic                 cmd_valid_i,
  input  cmd_desc_t            cmd_i,
  output logic                 cmd_ready_o,
  input  logic                 txq_valid_i,
  input  logic [WordWidth-1:0] txq_data_i,
  output logic                 txq_ready_o,
  output logic                 rx_valid_o,
  output logic [WordWidth-1:0] rx_data_o,
  input  logic                 rx_ready_i,
  output logic                 resp_valid_o,
  output resp_desc_t           resp_o,
  input  logic                 resp_ready_i,
  output logic                 err_o
);

  // Flow side of each queue
  logic                 cmd_q_valid, cmd_q_ready;
  cmd_desc_t            cmd_q_data;
  logic                 txq_q_valid, txq_q_ready;
  logic [WordWidth-1:0] txq_q_data;
  logic                 rx_q_valid, rx_q_ready;
  logic [WordWidth-1:0] rx_q_data;
  logic                 resp_q_valid, resp_q_ready;
  resp_desc_t           resp_q_data;

  flow_standby_i2c u_flow (
    .clk_i,
    .rst_ni,
    .acq_valid_i,
    .acq_i,
    .tx_byte_valid_o,
    .tx_byte_o,
    .tx_byte_ready_i,
    .cmd_valid_i    (cmd_q_valid),
    .cmd_i          (cmd_q_data),
    .cmd_ready_o    (cmd_q_ready),
    .txq_valid_i    (txq_q_valid),
    .txq_data_i     (txq_q_data),
    .txq_ready_o    (txq_q_ready),
    .rx_valid_o     (rx_q_valid),
    .rx_data_o      (rx_q_data),
    .rx_ready_i     (rx_q_ready),
    .resp_valid_o   (resp_q_valid),
    .resp_o         (resp_q_data),
    .resp_ready_i   (resp_q_ready),
    .err_o
  );

  sync_fifo #(.Width($bits(cmd_desc_t)), .Depth(QueueDepth)) u_cmd_q (
    .clk_i, .rst_ni,
    .wvalid_i (cmd_valid_i), .wdata_i (cmd_i),      .wready_o (cmd_ready_o),
    .rvalid_o (cmd_q_valid), .rdata_o (cmd_q_data), .rready_i (cmd_q_ready)
  );

  sync_fifo #(.Width(WordWidth), .Depth(QueueDepth)) u_txq (
    .clk_i, .rst_ni,
    .wvalid_i (txq_valid_i), .wdata_i (txq_data_i), .wready_o (txq_ready_o),
    .rvalid_o (txq_q_valid), .rdata_o (txq_q_data), .rready_i (txq_q_ready)
  );

  sync_fifo #(.Width(WordWidth), .Depth(QueueDepth)) u_rx_q (
    .clk_i, .rst_ni,
    .wvalid_i (rx_q_valid), .wdata_i (rx_q_data), .wready_o (rx_q_ready),
    .rvalid_o (rx_valid_o), .rdata_o (rx_data_o), .rready_i (rx_ready_i)
  );

  sync_fifo #(.Width($bits(resp_desc_t)), .Depth(QueueDepth)) u_resp_q (
    .clk_i, .rst_ni,
    .wvalid_i (resp_q_valid), .wdata_i (resp_q_data), .wready_o (resp_q_ready),
    .rvalid_o (resp_valid_o), .rdata_o (resp_o),      .rready_i (resp_ready_i)
  );

endmodule

//--- flow/flow_standby_i2c.sv
// Standby I2C target flow; turns bus engine events into host queue traffic and flags faults
`timescale 1ns/1ps

module flow_standby_i2c
  import standby_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Bus engine side
  input  logic                 acq_valid_i,
  input  acq_entry_t           acq_i,
  output logic                 tx_byte_valid_o,
  output logic [7:0]           tx_byte_o,
  input  logic                 tx_byte_ready_i,
  // Queue read ports
  input  logic                 cmd_valid_i,
  input  cmd_desc_t            cmd_i,
  output logic                 cmd_ready_o,
  input  logic                 txq_valid_i,
  input  logic [WordWidth-1:0] txq_data_i,
  output logic                 txq_ready_o,
  // Queue write ports
  output logic                 rx_valid_o,
  output logic [WordWidth-1:0] rx_data_o,
  input  logic                 rx_ready_i,
  output logic                 resp_valid_o,
  output resp_desc_t           resp_o,
  input  logic                 resp_ready_i,
  output logic                 err_o
);

  flow_state_e state_q, state_d;

  logic [15:0]          byte_cnt_q;
  logic [15:0]          rd_len_q;
  logic [15:0]          resp_len_q;
  logic [WordWidth-1:0] word_q;
  logic                 active_q;
  logic                 restart_pend_q;
  logic                 restart_read_q;
  logic [1:0]           lane;

  // Event decode
  logic start_seen, data_seen, end_seen, restart_seen, addr_read;
  // FSM controls for the registers
  logic begin_xfer, begin_write, end_xfer, take_byte, byte_step;

  assign lane         = byte_cnt_q[1:0];
  assign data_seen    = acq_valid_i & (acq_i.id == AcqData);
  assign restart_seen = acq_valid_i & (acq_i.id == AcqRestart);
  assign end_seen     = acq_valid_i & (acq_i.id == AcqStop) | restart_seen;
  assign start_seen   = acq_valid_i & (acq_i.id == AcqStart) | restart_seen;
  assign addr_read    = acq_i.data[0];

  assign byte_step = take_byte | (tx_byte_valid_o & tx_byte_ready_i);
  assign rx_data_o = word_q;
  assign tx_byte_o = word_q[{lane, 3'b000} +: 8];
  assign resp_o    = '{data_length: resp_len_q, err_status: RespOk};
  assign err_o     = (state_q == ReportError);

  always_comb begin
    state_d         = state_q;
    begin_xfer      = 1'b0;
    begin_write     = 1'b0;
    end_xfer        = 1'b0;
    take_byte       = 1'b0;
    cmd_ready_o     = 1'b0;
    txq_ready_o     = 1'b0;
    rx_valid_o      = 1'b0;
    resp_valid_o    = 1'b0;
    tx_byte_valid_o = 1'b0;

    unique case (state_q)
      AwaitStart: begin
        // A nacked address or a lone stop belongs to another target
        if (start_seen) begin
          begin_xfer  = 1'b1;
          begin_write = !addr_read;
          state_d     = addr_read ? PopCommand : ReceiveByte;
        end else if (data_seen) begin
          state_d = ReportError;
        end
      end
      ReceiveByte: begin
        if (data_seen) begin
          take_byte = 1'b1;
          if (lane == 2'd3) state_d = PushWord;
        end else if (end_seen) begin
          end_xfer = 1'b1;
          state_d  = (lane != 2'd0) ? PushWord : PushResponse;
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PushWord: begin
        rx_valid_o = 1'b1;
        if (acq_valid_i && !end_seen) begin
          state_d = ReportError;
        end else begin
          end_xfer = end_seen & active_q;
          if (rx_ready_i) state_d = (active_q && !end_seen) ? ReceiveByte : PushResponse;
        end
      end
      PushResponse: begin
        resp_valid_o = 1'b1;
        if (acq_valid_i && !end_seen) begin
          state_d = ReportError;
        end else if (resp_ready_i) begin
          if (restart_pend_q) begin
            begin_xfer  = 1'b1;
            begin_write = !restart_read_q;
            state_d     = restart_read_q ? PopCommand : ReceiveByte;
          end else begin
            state_d = AwaitStart;
          end
        end
      end
      PopCommand: begin
        cmd_ready_o = 1'b1;
        if (acq_valid_i) state_d = ReportError;
        else if (cmd_valid_i) state_d = (cmd_i.data_length == '0) ? ReportError : PopWord;
      end
      PopWord: begin
        txq_ready_o = 1'b1;
        if (acq_valid_i) state_d = ReportError;
        else if (txq_valid_i) state_d = SendByte;
      end
      SendByte: begin
        tx_byte_valid_o = 1'b1;
        if (acq_valid_i) begin
          state_d = ReportError;
        end else if (tx_byte_ready_i) begin
          state_d = (byte_cnt_q + 16'd1 == rd_len_q) ? AwaitStop : NextByte;
        end
      end
      NextByte: begin
        // Counter has moved on, fetch a new word at a lane wrap
        if (acq_valid_i) state_d = ReportError;
        else state_d = (lane == 2'd0) ? PopWord : SendByte;
      end
      AwaitStop: begin
        if (restart_seen) begin
          begin_xfer  = 1'b1;
          begin_write = !addr_read;
          state_d     = addr_read ? PopCommand : ReceiveByte;
        end else if (end_seen) begin
          state_d = AwaitStart;
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      ReportError: state_d = ReportError;
      default: state_d = ReportError;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= AwaitStart;
      byte_cnt_q     <= '0;
      rd_len_q       <= '0;
      resp_len_q     <= '0;
      active_q       <= 1'b0;
      restart_pend_q <= 1'b0;
      restart_read_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (begin_xfer) byte_cnt_q <= '0;
      else if (byte_step) byte_cnt_q <= byte_cnt_q + 16'd1;
      if (begin_xfer) active_q <= begin_write;
      else if (end_xfer) active_q <= 1'b0;
      if (end_xfer) resp_len_q <= byte_cnt_q;
      // A restart that ends a write opens the next transfer once the response is out
      if (end_xfer && restart_seen) begin
        restart_pend_q <= 1'b1;
        restart_read_q <= addr_read;
      end else if (begin_xfer) begin
        restart_pend_q <= 1'b0;
      end
      if (cmd_ready_o && cmd_valid_i) rd_len_q <= cmd_i.data_length;
    end
  end

  // Lane 0 clears the upper bytes, which pads a partial last word
  always_ff @(posedge clk_i) begin
    if (take_byte) begin
      if (lane == 2'd0) word_q <= WordWidth'(acq_i.data);
      else word_q[{lane, 3'b000} +: 8] <= acq_i.data;
    end else if (txq_ready_o && txq_valid_i) begin
      word_q <= txq_data_i;
    end
  end

  tx_byte_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_byte_valid_o && !tx_byte_ready_i |=> (tx_byte_valid_o && $stable(tx_byte_o)) || err_o);
  err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |=> err_o);

endmodule

//--- logic/sync_fifo.sv
// Synchronous valid/ready FIFO, instantiated once per host queue with its own width and depth
`timescale 1ns/1ps

module sync_fifo #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  input  logic [Width-1:0] wdata_i,
  output logic             wready_o,
  output logic             rvalid_o,
  output logic [Width-1:0] rdata_o,
  input  logic             rready_i
);

  localparam int PtrW = $clog2(Depth);
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [CntW-1:0]  count_q, count_d;
  logic             wready_q;
  logic             push, pop;

  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;
  assign wready_o = wready_q;
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];

  always_comb begin
    count_d = count_q;
    if (push && !pop) count_d = count_q + 1'b1;
    else if (pop && !push) count_d = count_q - 1'b1;
  end

  // Ready is registered, so it stays low until the first edge after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q   <= '0;
      rptr_q   <= '0;
      count_q  <= '0;
      wready_q <= 1'b0;
    end else begin
      if (push) wptr_q <= wptr_q + 1'b1;
      if (pop) rptr_q <= rptr_q + 1'b1;
      count_q  <= count_d;
      wready_q <= (count_d != CntW'(Depth));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= wdata_i;
  end

  count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CntW'(Depth));
  no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push && count_q == CntW'(Depth)));

endmodule

//--- common/standby_pkg.sv
// Types and constants shared by the standby I2C target flow RTL and its testbench
package standby_pkg;

  // Data queue word size in bits
  parameter int WordWidth = 32;

  // Kind of event reported by the I2C target bus engine
  typedef enum logic [2:0] {
    AcqData      = 3'd0,
    AcqStart     = 3'd1,
    AcqRestart   = 3'd2,
    AcqStop      = 3'd3,
    AcqNack      = 3'd4,
    AcqNackStart = 3'd5
  } acq_id_e;

  // One bus event; start and restart carry the address byte, bit 0 set means read
  typedef struct packed {
    acq_id_e    id;
    logic [7:0] data;
  } acq_entry_t;

  // Host command, number of bytes to send on a read
  typedef struct packed {
    logic [15:0] data_length;
  } cmd_desc_t;

  typedef enum logic [3:0] {
    RespOk       = 4'd0,
    RespOverflow = 4'd1
  } resp_err_e;

  // Response written at the end of a write transfer
  typedef struct packed {
    logic [15:0] data_length;
    resp_err_e   err_status;
  } resp_desc_t;

  typedef enum logic [3:0] {
    AwaitStart   = 4'd0,
    ReceiveByte  = 4'd1,
    PushWord     = 4'd2,
    PushResponse = 4'd3,
    PopCommand   = 4'd4,
    PopWord      = 4'd5,
    SendByte     = 4'd6,
    NextByte     = 4'd7,
    AwaitStop    = 4'd8,
    ReportError  = 4'd9
  } flow_state_e;

endpackage
